// ==== verilog/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// microinstruction word width.
`define IR_SIZE 36

// data path word.
`define DATA_W 16

// byte lane inside a data word.
`define BYTE_W 8

// physical address out of segment plus offset.
`define ADDR_W 20

// register file depth.
`define NUM_REGS 16

`endif

// ==== verilog/exec_pkg.sv ====
`include "exec_settings.svh"

package exec_pkg;

  // ALU operation classes, selected by the t field.
  typedef enum logic [2:0] {
    ARITH = 3'd0,
    LOGIC = 3'd1,
    SHIFT = 3'd2,
    MOVE  = 3'd3,
    ADDR  = 3'd4,
    MUL   = 3'd5
  } alu_class_e;

  typedef struct packed {
    logic             c_byte;
    logic             a_byte;
    logic             b_imm;
    logic             m_io;
    logic             mem_op;
    logic             memalu;
    logic             byteop;
    logic [2:0]       func;
    alu_class_e       t;
    logic             high;
    logic             wr_cnd;
    logic             wr;
    logic             wr_mem;
    logic             wrfl;
    logic [3:0]       addr_d;
    logic [3:0]       addr_c;
    logic [3:0]       addr_b;
    logic [3:0]       addr_a;
    logic [1:0]       addr_s;
  } micro_ir_t;

  typedef struct packed {
    logic [`BYTE_W-1:0] hi;
    logic [`BYTE_W-1:0] lo;
  } byte_pair_t;

  // a register is read as one word or as two byte registers.
  typedef union packed {
    logic [`DATA_W-1:0] word;
    byte_pair_t         bytes;
  } word_u;

  // x86 flag layout with the unused bits held at zero.
  typedef struct packed {
    logic [3:0] rsvd_hi;
    logic       of;
    logic [2:0] rsvd_mid;
    logic       sf;
    logic       zf;
    logic [2:0] rsvd_lo;
    logic       pf;
    logic       rsvd_1;
    logic       cf;
  } flags_t;

  typedef struct packed {
    logic wr_reg;
    logic wr_flags;
    logic high;
    logic byteop;
    logic memalu;
    logic b_imm;
    logic m_io;
    logic we;
  } ctrl_t;

endpackage

// ==== verilog/micro_decode.sv ====
`timescale 1ns/1ps

`include "exec_settings.svh"

module micro_decode (
  input  logic [`IR_SIZE-1:0]  ir,
  input  exec_pkg::flags_t     flags,
  input  exec_pkg::word_u      c_val,
  input  logic                 block,
  output logic [3:0]           addr_a,
  output logic [3:0]           addr_b,
  output logic [3:0]           addr_c,
  output logic [3:0]           addr_d,
  output logic [1:0]           addr_s,
  output exec_pkg::alu_class_e t,
  output logic [2:0]           func,
  output logic                 a_byte,
  output logic                 c_byte,
  output exec_pkg::ctrl_t      ctrl
);
  import exec_pkg::*;

  micro_ir_t uir;
  logic      base_cond;
  logic      cond;

  assign uir = micro_ir_t'(ir);

  assign addr_a = uir.addr_a;
  assign addr_b = uir.addr_b;
  assign addr_c = uir.addr_c;
  assign addr_d = uir.addr_d;
  assign addr_s = uir.addr_s;
  assign t      = uir.t;
  assign func   = uir.func;
  assign a_byte = uir.a_byte;
  assign c_byte = uir.c_byte;

  // even codes test the flag, odd codes its inverse.
  always_comb begin
    case (uir.addr_b[3:1])
      3'd0: base_cond = flags.of;
      3'd1: base_cond = flags.cf;
      3'd2: base_cond = flags.zf;
      3'd3: base_cond = flags.cf | flags.zf;
      3'd4: base_cond = flags.sf;
      3'd5: base_cond = flags.pf;
      3'd6: base_cond = flags.sf ^ flags.of;
      default: base_cond = flags.zf | (flags.sf ^ flags.of);
    endcase
  end

  // loop form tests the counter instead.
  assign cond = uir.addr_c[0] ? (c_val.word != '0) : (base_cond ^ uir.addr_b[0]);

  always_comb begin
    ctrl.wr_reg   = (uir.wr | (uir.wr_cnd & cond)) & ~block;
    ctrl.wr_flags = uir.wrfl & ~block;
    ctrl.high     = uir.high;
    ctrl.byteop   = uir.byteop;
    ctrl.memalu   = uir.memalu;
    ctrl.b_imm    = uir.b_imm;
    ctrl.m_io     = uir.m_io;
    // bus strobe is active low.
    ctrl.we       = ~uir.wr_mem;
  end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

`include "exec_settings.svh"

module alu (
  input  logic [31:0]          x,
  input  exec_pkg::word_u      y,
  input  exec_pkg::alu_class_e t,
  input  logic [2:0]           func,
  input  exec_pkg::flags_t     flags_in,
  input  logic                 word_op,
  input  logic [15:0]          seg,
  input  logic [15:0]          off,
  output logic [31:0]          result,
  output exec_pkg::flags_t     flags_out
);
  import exec_pkg::*;

  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] b_op;
  logic        c_in;
  logic [16:0] sum_w;
  logic [8:0]  sum_b;
  logic [15:0] res;
  logic [15:0] res_m;
  logic        cf_n;
  logic        of_n;
  logic        set_szp;
  logic [31:0] prod;
  logic [19:0] lin;

  function automatic logic top_bit(input logic [15:0] v, input logic wide);
    return wide ? v[15] : v[7];
  endfunction

  assign a = x[15:0];
  assign b = y.word;

  // subtract adds the complement with an inverted borrow.
  assign b_op  = func[1] ? ~b : b;
  assign c_in  = (func[0] & flags_in.cf) ^ func[1];
  assign sum_w = {1'b0, a} + {1'b0, b_op} + {16'h0000, c_in};
  assign sum_b = {1'b0, a[7:0]} + {1'b0, b_op[7:0]} + {8'h00, c_in};

  assign prod = word_op ? a * b : {24'h000000, a[7:0]} * {24'h000000, b[7:0]};
  assign lin  = {seg, 4'h0} + {4'h0, a} + {4'h0, off};

  always_comb begin
    res     = '0;
    cf_n    = flags_in.cf;
    of_n    = flags_in.of;
    set_szp = 1'b0;
    case (t)
      ARITH: begin
        res     = word_op ? sum_w[15:0] : {8'h00, sum_b[7:0]};
        cf_n    = (word_op ? sum_w[16] : sum_b[8]) ^ func[1];
        of_n    = (top_bit(a, word_op) == top_bit(b_op, word_op)) &&
                  (top_bit(res, word_op) != top_bit(a, word_op));
        set_szp = 1'b1;
      end
      LOGIC: begin
        case (func[1:0])
          2'd0: res = a & b;
          2'd1: res = a | b;
          2'd2: res = a ^ b;
          default: res = ~a;
        endcase
        cf_n    = 1'b0;
        of_n    = 1'b0;
        set_szp = 1'b1;
      end
      SHIFT: begin
        // the bit shifted out lands in cf.
        case (func[1:0])
          2'd0: res = {a[14:0], 1'b0};
          2'd1: res = word_op ? {1'b0, a[15:1]} : {9'h000, a[7:1]};
          2'd2: res = word_op ? {a[15], a[15:1]} : {8'h00, a[7], a[7:1]};
          default: res = word_op ? {a[14:0], a[15]} : {8'h00, a[6:0], a[7]};
        endcase
        cf_n    = (func[1:0] == 2'd1 || func[1:0] == 2'd2) ? a[0] : top_bit(a, word_op);
        set_szp = 1'b1;
      end
      MOVE: res = func[0] ? b : a;
      MUL: begin
        cf_n = word_op ? (prod[31:16] != '0) : (prod[15:8] != '0);
        of_n = cf_n;
      end
      default: res = '0;
    endcase
  end

  assign res_m = word_op ? res : {8'h00, res[7:0]};

  always_comb begin
    case (t)
      ADDR:    result = {12'h000, lin};
      MUL:     result = prod;
      default: result = {16'h0000, res_m};
    endcase
  end

  always_comb begin
    flags_out    = '0;
    flags_out.cf = cf_n;
    flags_out.of = of_n;
    flags_out.zf = set_szp ? (res_m == '0) : flags_in.zf;
    flags_out.sf = set_szp ? top_bit(res_m, word_op) : flags_in.sf;
    // parity covers the low byte only.
    flags_out.pf = set_szp ? ~^res_m[7:0] : flags_in.pf;
  end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

`include "exec_settings.svh"

module regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic [3:0]       addr_a,
  input  logic [3:0]       addr_b,
  input  logic [3:0]       addr_c,
  input  logic [3:0]       addr_d,
  input  logic [1:0]       addr_s,
  input  logic             a_byte,
  input  logic             c_byte,
  input  exec_pkg::ctrl_t  ctrl,
  input  logic [15:0]      wr_word,
  input  logic [15:0]      wr_high,
  input  exec_pkg::flags_t flags_in,
  output exec_pkg::word_u  a,
  output exec_pkg::word_u  b,
  output exec_pkg::word_u  c,
  output logic [15:0]      s,
  output logic [15:0]      cs,
  output exec_pkg::flags_t flags,
  output logic             cx_zero
);
  import exec_pkg::*;

  word_u regs [`NUM_REGS];
  word_u a_reg;
  word_u c_reg;

  // byte code picks the high or low half, zero extended.
  function automatic word_u byte_view(input word_u r, input logic hi);
    word_u v;
    v.word = {8'h00, hi ? r.bytes.hi : r.bytes.lo};
    return v;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      if (ctrl.wr_reg) begin
        if (ctrl.byteop) begin
          if (addr_d[2]) begin
            regs[addr_d[1:0]].bytes.hi <= wr_word[7:0];
          end else begin
            regs[addr_d[1:0]].bytes.lo <= wr_word[7:0];
          end
        end else begin
          regs[addr_d].word <= wr_word;
        end
        // upper product half goes to dx.
        if (ctrl.high) begin
          regs[2].word <= wr_high;
        end
      end
      if (ctrl.wr_flags) begin
        flags <= flags_in;
      end
    end
  end

  assign a_reg = regs[a_byte ? {2'b00, addr_a[1:0]} : addr_a];
  assign c_reg = regs[c_byte ? {2'b00, addr_c[1:0]} : addr_c];

  assign a = a_byte ? byte_view(a_reg, addr_a[2]) : a_reg;
  assign c = c_byte ? byte_view(c_reg, addr_c[2]) : c_reg;
  assign b = regs[addr_b];

  // segment registers sit at 12..15.
  assign s  = regs[{2'b11, addr_s}].word;
  assign cs = regs[13].word;

  assign cx_zero = (regs[1].word == '0);

endmodule

// ==== verilog/mem_port.sv ====
`timescale 1ns/1ps

`include "exec_settings.svh"

module mem_port (
  input  exec_pkg::ctrl_t   ctrl,
  input  logic [31:0]       aluout,
  input  logic [15:0]       memout,
  input  exec_pkg::word_u   c,
  input  logic              mem_op,
  input  logic              mem_rdy,
  output logic [`ADDR_W-1:0] addr,
  output logic              we,
  output logic              m_io,
  output logic              byteop,
  output logic [15:0]       wr_data,
  output logic [15:0]       wb_word,
  output logic              block
);
  import exec_pkg::*;

  // physical address comes straight from the adder.
  assign addr = aluout[`ADDR_W-1:0];

  assign we     = ctrl.we;
  assign m_io   = ctrl.m_io;
  assign byteop = ctrl.byteop;

  // store data is always register c.
  assign wr_data = c.word;

  // write-back picks ALU result or load data.
  assign wb_word = ctrl.memalu ? aluout[15:0] : memout;

  // stall while the memory has not answered.
  assign block = mem_op & ~mem_rdy;

endmodule

// ==== verilog/exec.sv ====
`timescale 1ns/1ps

`include "exec_settings.svh"

module exec (
  input  logic                clk,
  input  logic                rst,
  input  logic [`IR_SIZE-1:0] ir,
  input  logic [15:0]         off,
  input  logic [15:0]         imm,
  input  logic [15:0]         memout,
  input  logic                mem_rdy,
  output logic [15:0]         a,
  output logic [15:0]         wr_data,
  output logic [15:0]         cs,
  output logic [19:0]         addr,
  output logic                of,
  output logic                zf,
  output logic                cx_zero,
  output logic                we,
  output logic                m_io,
  output logic                byteop
);
  import exec_pkg::*;

  micro_ir_t  uir;
  ctrl_t      ctrl;
  alu_class_e t;
  word_u      a_w, b_w, c_w, bus_b;
  flags_t     flags, new_flags;
  logic [3:0] addr_a, addr_b, addr_c, addr_d;
  logic [1:0] addr_s;
  logic [2:0] func;
  logic       a_byte, c_byte, block;
  logic [15:0] s, wb_word;
  logic [31:0] aluout;

  assign uir = micro_ir_t'(ir);

  // second operand is the immediate or register b.
  assign bus_b.word = ctrl.b_imm ? imm : b_w.word;

  micro_decode dec0 (
    .ir(ir), .flags(flags), .c_val(c_w), .block(block),
    .addr_a(addr_a), .addr_b(addr_b), .addr_c(addr_c), .addr_d(addr_d),
    .addr_s(addr_s), .t(t), .func(func), .a_byte(a_byte), .c_byte(c_byte),
    .ctrl(ctrl)
  );

  alu alu0 (
    .x({c_w.word, a_w.word}), .y(bus_b), .t(t), .func(func), .flags_in(flags),
    .word_op(~ctrl.byteop), .seg(s), .off(off), .result(aluout),
    .flags_out(new_flags)
  );

  regfile reg0 (
    .clk(clk), .rst(rst), .addr_a(addr_a), .addr_b(addr_b), .addr_c(addr_c),
    .addr_d(addr_d), .addr_s(addr_s), .a_byte(a_byte), .c_byte(c_byte),
    .ctrl(ctrl), .wr_word(wb_word), .wr_high(aluout[31:16]), .flags_in(new_flags),
    .a(a_w), .b(b_w), .c(c_w), .s(s), .cs(cs), .flags(flags), .cx_zero(cx_zero)
  );

  mem_port mem0 (
    .ctrl(ctrl), .aluout(aluout), .memout(memout), .c(c_w), .mem_op(uir.mem_op),
    .mem_rdy(mem_rdy), .addr(addr), .we(we), .m_io(m_io), .byteop(byteop),
    .wr_data(wr_data), .wb_word(wb_word), .block(block)
  );

  assign a  = a_w.word;
  assign of = flags.of;
  assign zf = flags.zf;

endmodule

// ==== tests/tb_exec.sv ====
`timescale 1ns/1ps

`include "exec_settings.svh"

module tb_exec;
  import exec_pkg::*;

  typedef struct packed {
    logic [31:0] res;
    flags_t      fl;
  } alu_ref_t;

  logic                clk, rst, mem_rdy, chk_en;
  logic [`IR_SIZE-1:0] ir;
  logic [15:0]         off, imm, memout, a, wr_data, cs;
  logic [19:0]         addr;
  logic                of, zf, cx_zero, we, m_io, byteop;
  logic [15:0]         exp_a, exp_wr_data, exp_cs;
  logic [19:0]         exp_addr;
  logic                exp_of, exp_zf, exp_cx_zero, exp_we, exp_m_io, exp_byteop;
  logic [15:0]         shadow [16];
  flags_t              shadow_flags;
  integer              seed = 32'h9c22_3900;
  int                  mismatch_cnt = 0;
  int                  timeout_cnt = 0;

  exec UUT (
    .clk(clk), .rst(rst), .ir(ir), .off(off), .imm(imm), .memout(memout),
    .mem_rdy(mem_rdy), .a(a), .wr_data(wr_data), .cs(cs), .addr(addr), .of(of),
    .zf(zf), .cx_zero(cx_zero), .we(we), .m_io(m_io), .byteop(byteop)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x86 order where an odd code negates the test before it.
  function automatic logic cond_true(input logic [3:0] code, input flags_t f);
    logic [7:0] base;
    base = {f.zf | (f.sf ^ f.of), f.sf ^ f.of, f.pf, f.sf, f.cf | f.zf, f.zf, f.cf, f.of};
    return base[code[3:1]] ^ code[0];
  endfunction

  function automatic logic [15:0] read_port(input logic [3:0] idx, input logic as_byte);
    logic [15:0] r;
    r = shadow[idx[1:0]];
    if (!as_byte) return shadow[idx];
    return idx[2] ? {8'h00, r[15:8]} : {8'h00, r[7:0]};
  endfunction

  function automatic alu_ref_t ref_alu(input alu_class_e cls, input logic [2:0] fn,
                                       input logic [15:0] av, input logic [15:0] bv,
                                       input logic word, input flags_t fin,
                                       input logic [15:0] seg, input logic [15:0] offv);
    alu_ref_t    o;
    logic [16:0] full;
    logic [15:0] msk, am, bm, rv;
    logic        sa, sb, sr;
    msk   = word ? 16'hffff : 16'h00ff;
    am    = av & msk;
    bm    = bv & msk;
    sa    = word ? am[15] : am[7];
    o.fl  = fin;
    o.res = '0;
    rv    = '0;
    case (cls)
      ARITH: begin
        full = fn[1] ? {1'b0, am} - {1'b0, bm} - (fn[0] & fin.cf)
                     : {1'b0, am} + {1'b0, bm} + (fn[0] & fin.cf);
        rv = full[15:0] & msk;
        sb = word ? bm[15] : bm[7];
        sr = word ? rv[15] : rv[7];
        o.fl.cf = word ? full[16] : full[8];
        o.fl.of = (sr != sa) && (fn[1] ? (sa != sb) : (sa == sb));
      end
      LOGIC: begin
        rv = (fn[1:0] == 2'd0) ? am & bm : (fn[1:0] == 2'd1) ? am | bm :
             (fn[1:0] == 2'd2) ? am ^ bm : ~am & msk;
        o.fl.cf = 1'b0;
        o.fl.of = 1'b0;
      end
      SHIFT: begin
        rv = (fn[1:0] == 2'd0) ? (am << 1) & msk : (fn[1:0] == 2'd1) ? am >> 1 :
             (fn[1:0] == 2'd2) ? (am >> 1) | (am & ~(msk >> 1)) : ((am << 1) | sa) & msk;
        o.fl.cf = (fn[1:0] == 2'd1 || fn[1:0] == 2'd2) ? am[0] : sa;
      end
      MOVE: rv = fn[0] ? bm : am;
      MUL: begin
        o.res   = {16'h0000, am} * {16'h0000, bm};
        o.fl.cf = word ? (o.res[31:16] != 0) : (o.res[15:8] != 0);
        o.fl.of = o.fl.cf;
      end
      ADDR: o.res = (seg * 32'd16 + av + offv) & 32'h000f_ffff;
      default: rv = '0;
    endcase
    if (cls != MUL && cls != ADDR) o.res = {16'h0000, rv};
    if (cls == ARITH || cls == LOGIC || cls == SHIFT) begin
      o.fl.zf = (rv == 0);
      o.fl.sf = word ? rv[15] : rv[7];
      // even parity over the low byte.
      o.fl.pf = ~^rv[7:0];
    end
    return o;
  endfunction

  task automatic check_val(input string name, input logic [19:0] exp_v,
                           input logic [19:0] act_v);
    assert (act_v === exp_v) else begin
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
      mismatch_cnt++;
    end
  endtask

  always @(negedge clk) begin
    if (chk_en) begin
      check_val("a", exp_a, a);
      check_val("wr_data", exp_wr_data, wr_data);
      check_val("cs", exp_cs, cs);
      check_val("addr", exp_addr, addr);
      check_val("of", exp_of, of);
      check_val("zf", exp_zf, zf);
      check_val("cx_zero", exp_cx_zero, cx_zero);
      check_val("we", exp_we, we);
      check_val("m_io", exp_m_io, m_io);
      check_val("byteop", exp_byteop, byteop);
    end
  end

  // one microinstruction per cycle with the shadow state updated at the edge.
  task automatic issue(input micro_ir_t u, input logic [15:0] imm_v, input logic [15:0] off_v,
                       input logic [15:0] mem_v, input logic rdy);
    alu_ref_t    r;
    logic [15:0] wb;
    logic        commit, cond, wr_reg;
    ir          <= u;
    imm         <= imm_v;
    off         <= off_v;
    memout      <= mem_v;
    mem_rdy     <= rdy;
    exp_a       = read_port(u.addr_a, u.a_byte);
    exp_wr_data = read_port(u.addr_c, u.c_byte);
    r = ref_alu(u.t, u.func, exp_a, u.b_imm ? imm_v : shadow[u.addr_b], !u.byteop,
                shadow_flags, shadow[{2'b11, u.addr_s}], off_v);
    exp_addr    = r.res[19:0];
    exp_of      = shadow_flags.of;
    exp_zf      = shadow_flags.zf;
    exp_cx_zero = (shadow[1] == 16'h0000);
    exp_cs      = shadow[13];
    exp_we      = !u.wr_mem;
    exp_m_io    = u.m_io;
    exp_byteop  = u.byteop;
    chk_en      = 1'b1;
    cond   = u.addr_c[0] ? (exp_wr_data != 0) : cond_true(u.addr_b, shadow_flags);
    commit = !(u.mem_op && !rdy);
    wr_reg = commit && (u.wr || (u.wr_cnd && cond));
    wb     = u.memalu ? r.res[15:0] : mem_v;
    @(posedge clk);
    if (wr_reg) begin
      if (!u.byteop) begin
        shadow[u.addr_d] = wb;
      end else if (u.addr_d[2]) begin
        shadow[u.addr_d[1:0]][15:8] = wb[7:0];
      end else begin
        shadow[u.addr_d[1:0]][7:0] = wb[7:0];
      end
      if (u.high) shadow[2] = r.res[31:16];
    end
    if (commit && u.wrfl) shadow_flags = r.fl;
  endtask

  task automatic load_reg(input logic [3:0] idx, input logic [15:0] value);
    micro_ir_t u;
    u        = '0;
    u.t      = MOVE;
    u.mem_op = 1'b1;
    u.wr     = 1'b1;
    u.addr_d = idx;
    issue(u, 16'h0000, 16'h0000, value, 1'b1);
  endtask

  task automatic read_back(input logic [3:0] a_idx, input logic [3:0] c_idx);
    micro_ir_t u;
    u        = '0;
    u.t      = MOVE;
    u.addr_a = a_idx;
    u.addr_c = c_idx;
    issue(u, 16'h0000, 16'h0000, 16'h0000, 1'b1);
  endtask

  task automatic report_end();
    $display("errors: %0d value mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  initial begin
    #200_000;
    $display("timeout: stimulus did not complete within 200 us");
    timeout_cnt++;
    report_end();
  end

  initial begin
    micro_ir_t   u;
    logic [31:0] rv;
    int          n, k;
    rst          = 1'b1;
    ir           = '0;
    off          = '0;
    imm          = '0;
    memout       = '0;
    mem_rdy      = 1'b1;
    chk_en       = 1'b0;
    shadow_flags = '0;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    issue('0, 16'h0000, 16'h0000, 16'h0000, 1'b1);
    for (int r = 0; r < 16; r++) begin
      rv = $random(seed);
      load_reg(r[3:0], rv[15:0]);
      read_back(r[3:0], r[3:0]);
    end
    // random ALU work where byte ops read a as a byte register.
    for (int i = 0; i < 60; i++) begin
      rv       = $random(seed);
      k        = rv[31:17] % 5;
      u        = '0;
      u.t      = (k == 4) ? MUL : alu_class_e'(k);
      u.byteop = rv[0];
      u.a_byte = rv[0];
      u.b_imm  = rv[1];
      u.func   = {1'b0, rv[3:2]};
      u.addr_a = rv[0] ? {1'b0, rv[6:4]} : rv[7:4];
      u.addr_b = rv[11:8];
      u.addr_d = rv[0] ? {1'b0, rv[14:12]} : rv[15:12];
      u.high   = (u.t == MUL) && rv[16];
      u.wr     = 1'b1;
      u.wrfl   = 1'b1;
      u.memalu = 1'b1;
      rv = $random(seed);
      issue(u, rv[15:0], rv[31:16], 16'h0000, 1'b1);
      read_back(u.byteop ? {2'b00, u.addr_d[1:0]} : u.addr_d, 4'd2);
    end
    for (int i = 0; i < 20; i++) begin
      rv = $random(seed);
      load_reg({2'b11, rv[1:0]}, rv[31:16]);
      u        = '0;
      u.t      = ADDR;
      u.addr_s = rv[1:0];
      u.addr_a = rv[5:2];
      u.wr_mem = rv[6];
      u.m_io   = rv[7];
      u.byteop = rv[8];
      u.c_byte = rv[13];
      u.addr_c = rv[13] ? {1'b0, rv[11:9]} : rv[12:9];
      rv = $random(seed);
      issue(u, 16'h0000, rv[15:0], 16'h0000, 1'b1);
    end
    // codes 0..15 twice on random flags and then the loop form.
    for (int i = 0; i < 40; i++) begin
      rv       = $random(seed);
      u        = '0;
      u.t      = ARITH;
      u.func   = {1'b0, rv[1:0]};
      u.addr_a = rv[5:2];
      u.b_imm  = 1'b1;
      u.wrfl   = 1'b1;
      issue(u, rv[31:16], 16'h0000, 16'h0000, 1'b1);
      rv       = $random(seed);
      u        = '0;
      u.t      = MOVE;
      u.func   = 3'd1;
      u.b_imm  = 1'b1;
      u.memalu = 1'b1;
      u.wr_cnd = 1'b1;
      u.addr_b = i[3:0];
      u.addr_d = rv[3:0];
      u.addr_c = {rv[6:4], i >= 32};
      if (i >= 32) load_reg(u.addr_c, rv[7] ? 16'h0000 : rv[31:16]);
      issue(u, rv[31:16] ^ 16'h5a5a, 16'h0000, 16'h0000, 1'b1);
      read_back(u.addr_d, u.addr_c);
    end
    for (int i = 0; i < 4; i++) begin
      rv       = $random(seed);
      n        = 1 + rv[31:8] % 5;
      u        = '0;
      u.t      = ARITH;
      u.mem_op = 1'b1;
      u.wr     = 1'b1;
      u.wrfl   = 1'b1;
      u.addr_d = rv[3:0];
      u.addr_a = rv[3:0];
      u.addr_b = rv[7:4];
      rv = $random(seed);
      // the same load repeats while memory holds off.
      repeat (n) begin
        issue(u, 16'h0000, 16'h0000, rv[15:0], 1'b0);
      end
      issue(u, 16'h0000, 16'h0000, rv[15:0], 1'b1);
      read_back(u.addr_d, u.addr_d);
    end
    report_end();
  end

endmodule

// ==== exec.f ====
+incdir+verilog
verilog/exec_pkg.sv
verilog/micro_decode.sv
verilog/alu.sv
verilog/regfile.sv
verilog/mem_port.sv
verilog/exec.sv
tests/tb_exec.sv

// ==== Bender.yml ====
package:
  name: exec

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/exec_pkg.sv
      - verilog/micro_decode.sv
      - verilog/alu.sv
      - verilog/regfile.sv
      - verilog/mem_port.sv
      - verilog/exec.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_exec.sv
